// ==== dpTypesPkg.sv ====
`default_nettype none

package dpTypesPkg;

    localparam int DATA_W   = 32; // Bus and register width
    localparam int NUM_REGS = 16;
    localparam int IMM_W    = 23; // LDI immediate field

    typedef logic [3:0] regIdxT;

    typedef enum logic [4:0] {
        OP_LDM = 5'd0,  // Ra <= memory data via MDR
        OP_LDI = 5'd1,  // Ra <= sign-extended immediate
        OP_ADD = 5'd2,
        OP_SUB = 5'd3,
        OP_AND = 5'd4,
        OP_OR  = 5'd5,
        OP_XOR = 5'd6,
        OP_SHL = 5'd7,  // Shift amount from Rc[4:0]
        OP_SHR = 5'd8,  // Logical shift
        OP_NOT = 5'd9   // Invert Rb, Rc unused
    } aluOpT;

    // Two-register ALU form
    typedef struct packed {
        aluOpT       opcode;
        regIdxT      ra;
        regIdxT      rb;
        regIdxT      rc;
        logic [14:0] unused;
    } aluFmtT;

    // Immediate form for LDI
    typedef struct packed {
        aluOpT            opcode;
        regIdxT           ra;
        logic [IMM_W-1:0] imm;
    } immFmtT;

    // Same word seen through either format
    typedef union packed {
        aluFmtT aluFmt;
        immFmtT immFmt;
    } instrT;

endpackage

`default_nettype wire

// ==== ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    import dpTypesPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOADREG,  // LDM and LDI
        ALUOP,    // Three-step register operation
        RESP      // Holding result for the host
    } seqStateT;

    // Which block owns the shared bus this cycle
    typedef enum logic [2:0] {
        SRC_NONE  = 3'd0,
        SRC_REG   = 3'd1,
        SRC_MDR   = 3'd2,
        SRC_CONST = 3'd3,
        SRC_Z     = 3'd4
    } busSrcT;

    typedef struct packed {
        busSrcT busSrc;
        regIdxT regRdIdx;
        logic   regWrEn;
        regIdxT regWrIdx;
        logic   yIn;
        logic   zIn;
        aluOpT  aluOp;
    } busCtrlT;

    localparam logic [1:0] LOAD_STEPS = 2'd1;
    localparam logic [1:0] ALU_STEPS  = 2'd3;

endpackage

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile
    import dpTypesPkg::*;
    import ctrlPkg::*;
(
    input  logic              clock,
    input  logic              rstN,
    input  busCtrlT           busCtrl,
    input  logic [DATA_W-1:0] bus,
    output logic [DATA_W-1:0] rdData
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    // Single write port fed from the bus
    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (busCtrl.regWrEn) begin
            regs[busCtrl.regWrIdx] <= bus;
        end
    end

    assign rdData = regs[busCtrl.regRdIdx]; // Combinational read

endmodule

`default_nettype wire

// ==== aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit
    import dpTypesPkg::*;
    import ctrlPkg::*;
(
    input  logic              clock,
    input  logic              rstN,
    input  busCtrlT           busCtrl,
    input  logic [DATA_W-1:0] bus,
    output logic [DATA_W-1:0] zOut
);

    logic [DATA_W-1:0] yReg;
    logic [DATA_W-1:0] aluResult;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            yReg <= '0;
        end else if (busCtrl.yIn) begin
            yReg <= bus; // First operand
        end
    end

    // Y is the left operand, the bus carries the right one
    always_comb begin
        case (busCtrl.aluOp)
            OP_ADD:  aluResult = yReg + bus;
            OP_SUB:  aluResult = yReg - bus;
            OP_AND:  aluResult = yReg & bus;
            OP_OR:   aluResult = yReg | bus;
            OP_XOR:  aluResult = yReg ^ bus;
            OP_SHL:  aluResult = yReg << bus[4:0];
            OP_SHR:  aluResult = yReg >> bus[4:0];
            OP_NOT:  aluResult = ~yReg;
            default: aluResult = '0; // Loads never use the ALU
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            zOut <= '0;
        end else if (busCtrl.zIn) begin
            zOut <= aluResult;
        end
    end

    // Y and Z share the bus on consecutive steps, never the same one
    assert property (@(posedge clock) disable iff (!rstN) !(busCtrl.yIn && busCtrl.zIn))
        else $error("yIn and zIn both high");

endmodule

`default_nettype wire

// ==== busSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module busSelect
    import dpTypesPkg::*;
    import ctrlPkg::*;
(
    input  logic              clock,
    input  logic              rstN,
    input  busCtrlT           busCtrl,
    input  logic              irLoad,
    input  instrT             cmdInstr,
    input  logic [DATA_W-1:0] cmdData,
    input  logic [DATA_W-1:0] rdData,
    input  logic [DATA_W-1:0] zOut,
    output instrT             ir,
    output logic [DATA_W-1:0] bus
);

    logic [DATA_W-1:0] mdr;
    logic [DATA_W-1:0] constVal;

    // IR and MDR load together on command acceptance
    always_ff @(posedge clock) begin
        if (!rstN) begin
            ir  <= '0;
            mdr <= '0;
        end else if (irLoad) begin
            ir  <= cmdInstr;
            mdr <= cmdData;
        end
    end

    assign constVal = {{(DATA_W-IMM_W){ir.immFmt.imm[IMM_W-1]}}, ir.immFmt.imm};

    always_comb begin
        case (busCtrl.busSrc)
            SRC_REG:   bus = rdData;
            SRC_MDR:   bus = mdr;
            SRC_CONST: bus = constVal; // Sign-extended immediate
            SRC_Z:     bus = zOut;
            default:   bus = '0;       // Idle bus reads as zero
        endcase
    end

    // A register write must always have a real driver on the bus
    assert property (@(posedge clock) disable iff (!rstN)
        busCtrl.regWrEn |-> busCtrl.busSrc inside {SRC_REG, SRC_MDR, SRC_CONST, SRC_Z})
        else $error("Register write with illegal bus source %0h", busCtrl.busSrc);

endmodule

`default_nettype wire

// ==== stepCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module stepCounter (
    input  logic       clock,
    input  logic       rstN,
    input  logic       stepClear,
    input  logic       stepEnable,
    input  logic [1:0] stepLimit,
    output logic [1:0] stepCount,
    output logic       lastStep
);

    assign lastStep = (stepCount == stepLimit - 2'd1);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            stepCount <= '0;
        end else if (stepClear) begin
            stepCount <= '0;
        end else if (stepEnable) begin
            stepCount <= lastStep ? 2'd0 : stepCount + 2'd1; // Wrap after final step
        end
    end

    // Limit comes from the sequencer's instruction class
    assert property (@(posedge clock) disable iff (!rstN) stepEnable |-> stepCount < stepLimit)
        else $error("Step count %0d reached limit %0d", stepCount, stepLimit);

endmodule

`default_nettype wire

// ==== controlSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSequencer
    import dpTypesPkg::*;
    import ctrlPkg::*;
(
    input  logic       clock,
    input  logic       rstN,
    input  logic       cmdValid,
    output logic       cmdReady,
    input  aluOpT      cmdOpcode,
    output logic       respValid,
    input  logic       respReady,
    output regIdxT     respReg,
    input  instrT      ir,
    input  logic [1:0] stepCount,
    input  logic       lastStep,
    output logic       stepClear,
    output logic       stepEnable,
    output logic [1:0] stepLimit,
    output logic       irLoad,
    output busCtrlT    busCtrl
);

    seqStateT state, nextState;

    assign cmdReady  = (state == IDLE);
    assign respValid = (state == RESP);
    assign respReg   = ir.aluFmt.ra;
    assign irLoad    = cmdValid && cmdReady;

    assign stepClear  = (state == IDLE) || (state == RESP);
    assign stepEnable = (state == LOADREG) || (state == ALUOP);
    assign stepLimit  = (state == ALUOP) ? ALU_STEPS : LOAD_STEPS;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (irLoad) begin
                    nextState = (cmdOpcode inside {OP_LDM, OP_LDI}) ? LOADREG : ALUOP;
                end
            end
            LOADREG, ALUOP: begin
                if (lastStep) nextState = RESP;
            end
            RESP: begin
                if (respReady) nextState = IDLE; // Result taken
            end
            default: nextState = IDLE;
        endcase
    end

    // Control word per state and step
    always_comb begin
        busCtrl = '0;
        case (state)
            LOADREG: begin
                busCtrl.busSrc   = (ir.immFmt.opcode == OP_LDI) ? SRC_CONST : SRC_MDR;
                busCtrl.regWrEn  = 1'b1;
                busCtrl.regWrIdx = ir.immFmt.ra;
            end
            ALUOP: begin
                case (stepCount)
                    2'd0: begin
                        busCtrl.busSrc   = SRC_REG; // Rb into Y
                        busCtrl.regRdIdx = ir.aluFmt.rb;
                        busCtrl.yIn      = 1'b1;
                    end
                    2'd1: begin
                        busCtrl.busSrc   = SRC_REG; // Rc onto bus, result into Z
                        busCtrl.regRdIdx = ir.aluFmt.rc;
                        busCtrl.zIn      = 1'b1;
                        busCtrl.aluOp    = ir.aluFmt.opcode;
                    end
                    default: begin
                        busCtrl.busSrc   = SRC_Z;
                        busCtrl.regWrEn  = 1'b1;
                        busCtrl.regWrIdx = ir.aluFmt.ra;
                    end
                endcase
            end
            RESP: begin
                busCtrl.busSrc   = SRC_REG; // Ra drives respData
                busCtrl.regRdIdx = ir.aluFmt.ra;
            end
            default: ;
        endcase
    end

    // Acceptance always starts the steps of one instruction
    assert property (@(posedge clock) disable iff (!rstN) irLoad |=> !cmdReady && !respValid)
        else $error("Accepted command did not start its steps");

endmodule

`default_nettype wire

// ==== singleBusCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module singleBusCpu
    import dpTypesPkg::*;
    import ctrlPkg::*;
(
    input  logic              clock,
    input  logic              rstN,
    input  logic              cmdValid,
    output logic              cmdReady,
    input  instrT             cmdInstr,
    input  logic [DATA_W-1:0] cmdData,
    output logic              respValid,
    input  logic              respReady,
    output regIdxT            respReg,
    output logic [DATA_W-1:0] respData
);

    busCtrlT           busCtrl;
    instrT             ir;
    logic              irLoad;
    logic              stepClear;
    logic              stepEnable;
    logic [1:0]        stepLimit;
    logic [1:0]        stepCount;
    logic              lastStep;
    logic [DATA_W-1:0] bus;
    logic [DATA_W-1:0] rdData;
    logic [DATA_W-1:0] zOut;

    controlSequencer i_seq (
        .clock      (clock),
        .rstN       (rstN),
        .cmdValid   (cmdValid),
        .cmdReady   (cmdReady),
        .cmdOpcode  (cmdInstr.aluFmt.opcode), // Opcode sits at the same place in both forms
        .respValid  (respValid),
        .respReady  (respReady),
        .respReg    (respReg),
        .ir         (ir),
        .stepCount  (stepCount),
        .lastStep   (lastStep),
        .stepClear  (stepClear),
        .stepEnable (stepEnable),
        .stepLimit  (stepLimit),
        .irLoad     (irLoad),
        .busCtrl    (busCtrl)
    );

    stepCounter i_steps (
        .clock      (clock),
        .rstN       (rstN),
        .stepClear  (stepClear),
        .stepEnable (stepEnable),
        .stepLimit  (stepLimit),
        .stepCount  (stepCount),
        .lastStep   (lastStep)
    );

    regFile i_regs (
        .clock   (clock),
        .rstN    (rstN),
        .busCtrl (busCtrl),
        .bus     (bus),
        .rdData  (rdData)
    );

    aluUnit i_alu (
        .clock   (clock),
        .rstN    (rstN),
        .busCtrl (busCtrl),
        .bus     (bus),
        .zOut    (zOut)
    );

    busSelect i_busSel (
        .clock    (clock),
        .rstN     (rstN),
        .busCtrl  (busCtrl),
        .irLoad   (irLoad),
        .cmdInstr (cmdInstr),
        .cmdData  (cmdData),
        .rdData   (rdData),
        .zOut     (zOut),
        .ir       (ir),
        .bus      (bus)
    );

    assign respData = bus; // Ra is on the bus throughout RESP

endmodule

`default_nettype wire

// ==== tbSingleBusCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbSingleBusCpu
    import dpTypesPkg::*;
();

    localparam int NUM_RANDOM = 200;
    localparam int TOTAL_CMDS = 2 + NUM_REGS + NUM_RANDOM; // Zero check, register fill, random
    localparam int MAX_CYCLES = NUM_RANDOM * 10 + 1000;    // About ten cycles per command

    logic              clock;
    logic              rstN;
    logic              cmdValid;
    logic              cmdReady;
    instrT             cmdInstr;
    logic [DATA_W-1:0] cmdData;
    logic              respValid;
    logic              respReady;
    regIdxT            respReg;
    logic [DATA_W-1:0] respData;

    logic [DATA_W-1:0] shadow [NUM_REGS]; // Reference register model
    logic [DATA_W-1:0] expData;
    regIdxT            expReg;
    logic              expLoad;
    logic              accept;
    int                taken;
    int                cycles    = 0;
    int                seed      = 32'h5622_8a1a;
    int                readySeed = 32'h5622_8a1a;

    singleBusCpu i_dut (
        .clock     (clock),
        .rstN      (rstN),
        .cmdValid  (cmdValid),
        .cmdReady  (cmdReady),
        .cmdInstr  (cmdInstr),
        .cmdData   (cmdData),
        .respValid (respValid),
        .respReady (respReady),
        .respReg   (respReg),
        .respData  (respData)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        stopWithError($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    function automatic instrT makeInstr(aluOpT op, regIdxT ra, regIdxT rb, regIdxT rc);
        instrT w;
        w = '0;
        w.aluFmt.opcode = op;
        w.aluFmt.ra     = ra;
        w.aluFmt.rb     = rb;
        w.aluFmt.rc     = rc;
        return w;
    endfunction

    // Expected Ra value, taken from the model before the write
    function automatic logic [31:0] predictResult(instrT w, logic [31:0] mem);
        logic [31:0] b;
        logic [31:0] c;
        b = shadow[w.aluFmt.rb];
        c = shadow[w.aluFmt.rc];
        case (w.aluFmt.opcode)
            OP_LDM:  return mem;
            OP_LDI:  return 32'(signed'(w.immFmt.imm)); // Sign extended
            OP_ADD:  return b + c;
            OP_SUB:  return b - c;
            OP_AND:  return b & c;
            OP_OR:   return b | c;
            OP_XOR:  return b ^ c;
            OP_SHL:  return b << c[4:0];
            OP_SHR:  return b >> c[4:0];
            OP_NOT:  return ~b;
            default: return 32'h0;
        endcase
    endfunction

    // Source side holds everything until the accepting edge has passed
    task automatic sendCommand(input instrT instr, input logic [31:0] data);
        cmdValid = 1'b1;
        cmdInstr = instr;
        cmdData  = data;
        while (!cmdReady) @(negedge clock);
        @(negedge clock);
        cmdValid = 1'b0;
    endtask

    assign accept = cmdValid && cmdReady;

    always @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                shadow[i] <= '0;
            end
            taken <= 0;
        end else begin
            if (accept) begin
                expData <= predictResult(cmdInstr, cmdData);
                expReg  <= cmdInstr.aluFmt.ra;
                expLoad <= cmdInstr.aluFmt.opcode inside {OP_LDM, OP_LDI};
            end
            if (respValid && respReady) begin
                shadow[expReg] <= expData; // Result retired
                taken          <= taken + 1;
            end
        end
    end

    always @(negedge clock) begin
        respReady = ($random(readySeed) & 3) != 0; // Withheld about one cycle in four
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) stopWithError("Timeout while waiting for results");
    end

    assert property (@(posedge clock) !rstN |=> cmdReady && !respValid)
        else stopWithError("Idle handshake state wrong after reset");

    assert property (@(posedge clock) disable iff (!rstN) respValid |-> respData == expData)
        else reportMismatch("respData", $sampled(respData), $sampled(expData));

    assert property (@(posedge clock) disable iff (!rstN) respValid |-> respReg == expReg)
        else reportMismatch("respReg", 32'($sampled(respReg)), 32'($sampled(expReg)));

    // Loads answer two samples after acceptance, ALU ops four
    assert property (@(posedge clock) disable iff (!rstN)
        $rose(respValid) |-> (expLoad ? $past(accept, 2) : $past(accept, 4)))
        else stopWithError("Result became valid at the wrong edge after acceptance");

    assert property (@(posedge clock) disable iff (!rstN) respValid && !respReady |=>
        respValid && !cmdReady && $stable(respData) && $stable(respReg))
        else stopWithError("Result changed or command accepted under back-pressure");

    initial begin
        instrT       w;
        logic [31:0] rnd;
        logic [31:0] data;
        logic [4:0]  opBits;
        respReady = 1'b0;
        cmdValid = 1'b0;
        cmdInstr = '0;
        cmdData  = '0;
        rstN     = 1'b0;
        repeat (3) @(negedge clock);
        rstN = 1'b1;

        // Registers read as zero straight after reset
        sendCommand(makeInstr(OP_LDM, 4'd0, 4'd0, 4'd0), 32'h0);
        sendCommand(makeInstr(OP_ADD, 4'd1, 4'd2, 4'd3), 32'h0);

        for (int r = 0; r < NUM_REGS; r++) begin
            rnd = $random(seed);
            w   = makeInstr(r[0] ? OP_LDI : OP_LDM, regIdxT'(r), 4'd0, 4'd0);
            if (r[0]) w.immFmt.imm = rnd[22:0];
            sendCommand(w, rnd);
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd    = $random(seed);
            data   = $random(seed);
            opBits = 5'(rnd[23:16] % 8'd10);
            w      = makeInstr(aluOpT'(opBits), rnd[3:0], rnd[7:4], rnd[11:8]);
            if (w.aluFmt.opcode == OP_LDI) w.immFmt.imm = data[22:0];
            if (rnd[12]) @(negedge clock); // Occasional idle cycle
            sendCommand(w, data);
        end

        while (taken != TOTAL_CMDS) @(negedge clock);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
dpTypesPkg.sv
ctrlPkg.sv
regFile.sv
aluUnit.sv
busSelect.sv
stepCounter.sv
controlSequencer.sv
singleBusCpu.sv
tbSingleBusCpu.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbSingleBusCpu -f flist.f \
    -o simSingleBusCpu > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simSingleBusCpu > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Everything OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
